// File: build.f
logic/rootDivPkg.sv
logic/opQueue.sv
logic/operandPrep.sv
logic/rootDivCore.sv
logic/dispatchCtrl.sv
logic/resultMux.sv
logic/rootDivCluster.sv
test/rootDivCluster_sva.sv
test/rootDivTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the cluster testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f build.f --top-module rootDivTb -Mdir obj_dir -o rootDivSim

output=$(./obj_dir/rootDivSim 2>&1) || true
echo "$output"
if ! grep -qx "No errors" <<< "$output"; then
  exit 1
fi

// File: test/rootDivStim.txt
# op A B tag reg expected dz, all hex
# op 0 divW, 1 sqrtW, 2 divB, 3 sqrtB; expected is {remainder, quotient or root}
# word divide
0 1234 0010 00 01 00040123 0
0 FFFF 0007 01 02 00012492 0
0 0064 00C8 02 1F 00640000 0
0 ABCD 0100 03 04 00CD00AB 0
0 8000 8001 04 05 80000000 0
0 FFFF FFFF 05 0A 00000001 0
0 03E8 0003 06 11 0001014D 0
0 7531 00FF 07 13 00A60075 0
# word square root
1 0000 0000 08 00 00000000 0
1 FFFF 0000 09 1E 01FE00FF 0
1 0051 0000 0A 07 00000009 0
1 0063 0000 0B 08 00120009 0
1 1000 0000 0C 09 00000040 0
1 3039 0000 0D 0C 0018006F 0
1 0002 0000 0E 0D 00010001 0
1 C350 0000 0F 0E 010F00DF 0
# byte divide, upper operand bits ignored
2 12C8 FF07 10 03 0004001C 0
2 00FF 0010 11 06 000F000F 0
2 AB05 0009 12 10 00050000 0
2 0080 0080 13 12 00000001 0
2 55F0 330C 14 14 00000014 0
2 00E7 0022 15 15 001B0006 0
# byte square root
3 00FF 0000 16 16 001E000F 0
3 FF00 0000 17 17 00000000 0
3 1290 0000 18 18 0000000C 0
3 0064 0000 19 19 0000000A 0
3 00C8 0000 1A 1A 0004000E 0
3 8003 0000 1B 1B 00020001 0
# divide by zero, byte divisor 0300 masks to zero
0 1234 0000 1C 1C 1234FFFF 1
0 0000 0000 1D 1D 0000FFFF 1
2 77AA 0300 1E 0B 00AA00FF 1
2 0011 0000 1F 0F 001100FF 1
# mixed modes
0 2710 0064 20 01 00000064 0
1 2710 0000 21 02 00000064 0
3 0031 0000 22 03 00000007 0
2 00FE 00FD 23 04 00010001 0
0 0001 0002 24 05 00010000 0
1 0008 0000 25 06 00040002 0
0 FEDC 0123 26 07 003C00E0 0
3 0011 0000 27 1F 00010004 0

// File: test/rootDivTb.sv
`timescale 1ns/100ps
`default_nettype none

module rootDivTb import rootDivPkg::*; ();
  localparam int numUnits   = 4;
  localparam int queueDepth = 4;
  localparam int maxTags    = 2 ** tagW;
  localparam int burstStart = 24;     // ops from here on are issued back to back
  localparam int seed       = 93508;

  logic                clk;
  logic                rst;
  logic                inEn;
  rootOpE              inOp;
  logic [operandW-1:0] inA;
  logic [operandW-1:0] inB;
  logic [tagW-1:0]     inTag;
  logic [regW-1:0]     inReg;
  logic                full;
  logic                outEn;
  logic [resultW-1:0]  outData;
  logic [tagW-1:0]     outTag;
  logic [regW-1:0]     outReg;
  logic                outDivZero;

  // operations in file order
  logic [1:0]          stimOp  [maxTags];
  logic [operandW-1:0] stimA   [maxTags];
  logic [operandW-1:0] stimB   [maxTags];
  logic [tagW-1:0]     stimTag [maxTags];
  logic [regW-1:0]     stimReg [maxTags];

  // scoreboard indexed by tag
  logic [resultW-1:0] expData    [maxTags];
  logic [regW-1:0]    expReg     [maxTags];
  logic               expDivZero [maxTags];
  logic               tagUsed    [maxTags];
  logic               tagSeen    [maxTags];

  int   numOps = 0;
  int   numResults = 0;
  int   cycleCount = 0;
  int   timeoutLimit = 0;
  logic sawFull = 1'b0;

  bind rootDivCluster rootDivCluster_sva #(.numUnits(numUnits)) sva (
    .clk(clk), .rst(rst), .inEn(inEn), .full(full), .outEn(outEn),
    .grant(grant), .done(done)
  );

  rootDivCluster #(.numUnits(numUnits), .queueDepth(queueDepth)) UUT (
    .clk(clk), .rst(rst), .inEn(inEn), .inOp(inOp), .inA(inA), .inB(inB),
    .inTag(inTag), .inReg(inReg), .full(full), .outEn(outEn), .outData(outData),
    .outTag(outTag), .outReg(outReg), .outDivZero(outDivZero)
  );

  task automatic stopWithFailure(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "run stopped");
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      stopWithFailure($sformatf("mismatch at %0t: %s is %h, expected %h",
                                $time, name, actual, expected));
    end
  endtask

  task automatic loadStimulus();
    int          fd;
    int          fields;
    string       line;
    logic [3:0]  op;
    logic [15:0] a;
    logic [15:0] b;
    logic [7:0]  tag;
    logic [7:0]  dest;
    logic [31:0] data;
    logic [3:0]  dz;
    fd = $fopen("test/rootDivStim.txt", "r");
    if (fd == 0) begin
      stopWithFailure("cannot open test/rootDivStim.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%h %h %h %h %h %h %h", op, a, b, tag, dest, data, dz);
          if (fields != 7 || tag >= 8'(maxTags) || numOps >= maxTags ||
              tagUsed[tag[tagW-1:0]]) begin
            stopWithFailure($sformatf("bad stimulus line: %s", line));
          end else begin
            stimOp[numOps]  = op[1:0];
            stimA[numOps]   = a;
            stimB[numOps]   = b;
            stimTag[numOps] = tag[tagW-1:0];
            stimReg[numOps] = dest[regW-1:0];
            expData[tag[tagW-1:0]]    = data;
            expReg[tag[tagW-1:0]]     = dest[regW-1:0];
            expDivZero[tag[tagW-1:0]] = dz[0];
            tagUsed[tag[tagW-1:0]]    = 1'b1;
            numOps++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // called on a falling edge, returns on the next one
  task automatic issueOp(input int idx);
    while (full) @(negedge clk);
    inEn  = 1'b1;
    inOp  = rootOpE'(stimOp[idx]);
    inA   = stimA[idx];
    inB   = stimB[idx];
    inTag = stimTag[idx];
    inReg = stimReg[idx];
    @(negedge clk);
    inEn = 1'b0;
  endtask

  task automatic checkResult();
    if (!tagUsed[outTag]) begin
      stopWithFailure($sformatf("result for tag %0d that was never issued", outTag));
    end else if (tagSeen[outTag]) begin
      stopWithFailure($sformatf("tag %0d returned a second time", outTag));
    end else begin
      tagSeen[outTag] = 1'b1;
      numResults++;
      checkValue("outData", outData, expData[outTag]);
      checkValue("outReg", 32'(outReg), 32'(expReg[outTag]));
      checkValue("outDivZero", 32'(outDivZero), 32'(expDivZero[outTag]));
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (timeoutLimit > 0 && cycleCount > timeoutLimit) begin
      stopWithFailure($sformatf("timeout after %0d cycles, %0d of %0d results seen",
                                cycleCount, numResults, numOps));
    end
  end

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (full) sawFull = 1'b1;
    if (!rst && outEn) checkResult();
  end

  initial begin
    int gap;
    void'($urandom(seed));
    rst   = 1'b1;
    inEn  = 1'b0;
    inOp  = opDivW;
    inA   = '0;
    inB   = '0;
    inTag = '0;
    inReg = '0;
    for (int t = 0; t < maxTags; t++) begin
      tagUsed[t] = 1'b0;
      tagSeen[t] = 1'b0;
    end
    loadStimulus();
    timeoutLimit = numOps * (stepsWord + 1 + 4 + 3) + 100;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < numOps; i++) begin
      issueOp(i);
      if (i < burstStart) begin
        gap = int'($urandom % 4);
        repeat (gap) @(negedge clk);
      end
    end
    while (numResults < numOps) @(negedge clk);
    repeat (4) @(negedge clk);  // catch a stray late strobe
    if (sawFull && numOps > 0) begin
      $display("No errors");
      $finish;
    end else begin
      stopWithFailure("full never went high during the back-to-back burst");
    end
  end

endmodule

`default_nettype wire

// File: test/rootDivCluster_sva.sv
`timescale 1ns/100ps
`default_nettype none

module rootDivCluster_sva #(
  parameter int numUnits = 4
) (
  input logic                clk,
  input logic                rst,
  input logic                inEn,
  input logic                full,
  input logic                outEn,
  input logic [numUnits-1:0] grant,
  input logic [numUnits-1:0] done
);

  issueWhileFull: assert property (@(posedge clk) disable iff (rst) !(inEn && full))
    else $error("inEn high while the queue is full");

  // a grant only ever goes to one finished unit
  grantOneHot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant) && ((grant & ~done) == '0))
    else $error("grant is not one-hot or hits a unit that is not done");

  quietAfterReset: assert property (@(posedge clk)
    rst |=> !outEn && !full && (grant == '0) && (done == '0))
    else $error("outputs or unit handshakes active right after reset");

  for (genvar i = 0; i < numUnits; i++) begin : waitGen
    logic [7:0] waitCnt;  // cycles done has waited for its grant

    always_ff @(posedge clk) begin
      if (rst) waitCnt <= '0;
      else if (!done[i] || grant[i]) waitCnt <= '0;
      else waitCnt <= waitCnt + 1'b1;
    end

    grantInTime: assert property (@(posedge clk) disable iff (rst) waitCnt < 8'(numUnits))
      else $error("unit %0d waited too long for its grant", i);

    grantReleases: assert property (@(posedge clk) disable iff (rst) grant[i] |=> !done[i])
      else $error("unit %0d still done after its grant", i);
  end

endmodule

`default_nettype wire

// File: logic/rootDivCluster.sv
`timescale 1ns/100ps
`default_nettype none

module rootDivCluster import rootDivPkg::*; #(
  parameter int numUnits   = 4,
  parameter int queueDepth = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                inEn,
  input  rootOpE              inOp,
  input  logic [operandW-1:0] inA,
  input  logic [operandW-1:0] inB,
  input  logic [tagW-1:0]     inTag,
  input  logic [regW-1:0]     inReg,
  output logic                full,
  output logic                outEn,
  output logic [resultW-1:0]  outData,
  output logic [tagW-1:0]     outTag,
  output logic [regW-1:0]     outReg,
  output logic                outDivZero
);
  localparam int idxW = (numUnits > 1) ? $clog2(numUnits) : 1;

  // queue head
  logic                queueValid;
  logic                pop;
  rootOpE              headOp;
  logic [operandW-1:0] headA;
  logic [operandW-1:0] headB;
  logic [tagW-1:0]     headTag;
  logic [regW-1:0]     headReg;

  // prepared operands, shared by all units
  logic [2*operandW-1:0] prepA;
  logic [operandW-1:0]   prepB;
  logic [stepW-1:0]      prepSteps;
  logic                  prepIsRoot;
  logic [tagW-1:0]       prepTag;
  logic [regW-1:0]       prepReg;

  logic [numUnits-1:0] ready;
  logic [numUnits-1:0] done;
  logic [numUnits-1:0] start;
  logic [numUnits-1:0] grant;
  logic                grantValid;
  logic [idxW-1:0]     grantIdx;

  logic [numUnits-1:0][resultW-1:0] unitResult;
  logic [numUnits-1:0][tagW-1:0]    unitTag;
  logic [numUnits-1:0][regW-1:0]    unitReg;
  logic [numUnits-1:0]              unitDivZero;

  opQueue #(.queueDepth(queueDepth)) queue (
    .clk(clk), .rst(rst), .inEn(inEn), .inOp(inOp), .inA(inA), .inB(inB),
    .inTag(inTag), .inReg(inReg), .pop(pop), .full(full), .queueValid(queueValid),
    .headOp(headOp), .headA(headA), .headB(headB), .headTag(headTag), .headReg(headReg)
  );

  operandPrep prep (
    .clk(clk), .rst(rst), .pop(pop), .headOp(headOp), .headA(headA), .headB(headB),
    .headTag(headTag), .headReg(headReg), .prepA(prepA), .prepB(prepB),
    .prepSteps(prepSteps), .prepIsRoot(prepIsRoot), .prepTag(prepTag), .prepReg(prepReg)
  );

  dispatchCtrl #(.numUnits(numUnits)) ctrl (
    .clk(clk), .rst(rst), .queueValid(queueValid), .ready(ready), .done(done),
    .pop(pop), .start(start), .grant(grant), .grantValid(grantValid), .grantIdx(grantIdx)
  );

  for (genvar i = 0; i < numUnits; i++) begin : unitGen
    rootDivCore core (
      .clk(clk), .rst(rst), .start(start[i]), .grant(grant[i]),
      .prepA(prepA), .prepB(prepB), .prepSteps(prepSteps), .prepIsRoot(prepIsRoot),
      .prepTag(prepTag), .prepReg(prepReg), .ready(ready[i]), .done(done[i]),
      .result(unitResult[i]), .resTag(unitTag[i]), .resReg(unitReg[i]),
      .resDivZero(unitDivZero[i])
    );
  end

  resultMux #(.numUnits(numUnits)) outMux (
    .clk(clk), .rst(rst), .grantValid(grantValid), .grantIdx(grantIdx),
    .unitResult(unitResult), .unitTag(unitTag), .unitReg(unitReg),
    .unitDivZero(unitDivZero), .outEn(outEn), .outData(outData), .outTag(outTag),
    .outReg(outReg), .outDivZero(outDivZero)
  );

endmodule

`default_nettype wire

// File: logic/resultMux.sv
`timescale 1ns/100ps
`default_nettype none

module resultMux import rootDivPkg::*; #(
  parameter  int numUnits = 4,
  localparam int idxW     = (numUnits > 1) ? $clog2(numUnits) : 1
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               grantValid,
  input  logic [idxW-1:0]                    grantIdx,
  input  logic [numUnits-1:0][resultW-1:0]   unitResult,
  input  logic [numUnits-1:0][tagW-1:0]      unitTag,
  input  logic [numUnits-1:0][regW-1:0]      unitReg,
  input  logic [numUnits-1:0]                unitDivZero,
  output logic                               outEn,
  output logic [resultW-1:0]                 outData,
  output logic [tagW-1:0]                    outTag,
  output logic [regW-1:0]                    outReg,
  output logic                               outDivZero
);

  always_ff @(posedge clk) begin
    if (rst) outEn <= 1'b0;
    else outEn <= grantValid;  // one-cycle strobe per grant
  end

  // fields hold their last value between strobes
  always_ff @(posedge clk) begin
    if (grantValid) begin
      outData    <= unitResult[grantIdx];
      outTag     <= unitTag[grantIdx];
      outReg     <= unitReg[grantIdx];
      outDivZero <= unitDivZero[grantIdx];
    end
  end

endmodule

`default_nettype wire

// File: logic/dispatchCtrl.sv
`timescale 1ns/100ps
`default_nettype none

module dispatchCtrl #(
  parameter  int numUnits = 4,
  localparam int idxW     = (numUnits > 1) ? $clog2(numUnits) : 1
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                queueValid,
  input  logic [numUnits-1:0] ready,
  input  logic [numUnits-1:0] done,
  output logic                pop,
  output logic [numUnits-1:0] start,
  output logic [numUnits-1:0] grant,
  output logic                grantValid,
  output logic [idxW-1:0]     grantIdx
);
  typedef enum logic {
    sIdle,
    sIssue
  } dispStateE;

  dispStateE       state;
  logic [idxW-1:0] freeIdx;
  logic [idxW-1:0] selIdx;   // unit picked at pop, started in sIssue
  logic            anyReady;

  // lowest ready unit wins
  always_comb begin
    freeIdx = '0;
    for (int i = numUnits - 1; i >= 0; i--) begin
      if (ready[i]) freeIdx = idxW'(i);
    end
  end

  assign anyReady = |ready;
  assign pop      = (state == sIdle) && queueValid && anyReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= sIdle;
      selIdx <= '0;
    end else begin
      case (state)
        sIdle: begin
          if (pop) begin
            state  <= sIssue;
            selIdx <= freeIdx;
          end
        end
        sIssue:  state <= sIdle;  // prep operands valid now
        default: state <= sIdle;
      endcase
    end
  end

  always_comb begin
    start = '0;
    if (state == sIssue) start[selIdx] = 1'b1;
  end

  // result side, fixed priority over finished units
  always_comb begin
    grant    = '0;
    grantIdx = '0;
    for (int i = numUnits - 1; i >= 0; i--) begin
      if (done[i]) grantIdx = idxW'(i);
    end
    grantValid = |done;
    if (grantValid) grant[grantIdx] = 1'b1;
  end

endmodule

`default_nettype wire

// File: logic/rootDivCore.sv
`timescale 1ns/100ps
`default_nettype none

module rootDivCore import rootDivPkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic                  grant,
  input  logic [2*operandW-1:0] prepA,
  input  logic [operandW-1:0]   prepB,
  input  logic [stepW-1:0]      prepSteps,
  input  logic                  prepIsRoot,
  input  logic [tagW-1:0]       prepTag,
  input  logic [regW-1:0]       prepReg,
  output logic                  ready,
  output logic                  done,
  output logic [resultW-1:0]    result,
  output logic [tagW-1:0]       resTag,
  output logic [regW-1:0]       resReg,
  output logic                  resDivZero
);
  // two guard bits above the operand width for the root trial value
  localparam int remW = operandW + 2;

  typedef enum logic [1:0] {
    stIdle,
    stRun,
    stHold
  } coreStateE;

  coreStateE             state;
  logic [stepW-1:0]      stepCnt;
  logic [2*operandW-1:0] srcReg;    // dividend or radicand, consumed from the top
  logic [operandW-1:0]   divisor;
  logic [operandW-1:0]   quo;       // quotient or root
  logic [remW-1:0]       partRem;
  logic [remW-1:0]       shRem;
  logic [remW-1:0]       trialSub;
  logic [remW-1:0]       nextRem;
  logic                  isRoot;
  logic                  fits;

  assign ready  = (state == stIdle);
  assign done   = (state == stHold);
  assign result = {partRem[operandW-1:0], quo};

  // one restoring step
  always_comb begin
    if (isRoot) begin
      shRem    = {partRem[remW-3:0], srcReg[2*operandW-1 -: 2]};
      trialSub = {quo, 2'b01};  // 4*root + 1
    end else begin
      shRem    = {partRem[remW-2:0], srcReg[2*operandW-1]};
      trialSub = {2'b00, divisor};
    end
    fits    = (shRem >= trialSub);
    nextRem = fits ? shRem - trialSub : shRem;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= stIdle;
      stepCnt <= '0;
    end else begin
      case (state)
        stIdle: begin
          if (start) begin
            state   <= stRun;
            stepCnt <= prepSteps;
          end
        end
        stRun: begin
          stepCnt <= stepCnt - 1'b1;
          if (stepCnt == stepW'(1)) state <= stHold;  // last step this cycle
        end
        stHold: begin
          if (grant) state <= stIdle;  // result stays until granted
        end
        default: state <= stIdle;
      endcase
    end
  end

  // zero divisor needs no special path: every step fits, so the quotient
  // fills with ones and the remainder collects the dividend
  always_ff @(posedge clk) begin
    if (state == stIdle && start) begin
      srcReg     <= prepA;
      divisor    <= prepB;
      isRoot     <= prepIsRoot;
      resTag     <= prepTag;
      resReg     <= prepReg;
      resDivZero <= !prepIsRoot && (prepB == '0);
      partRem    <= '0;
      quo        <= '0;
    end else if (state == stRun) begin
      srcReg  <= isRoot ? srcReg << 2 : srcReg << 1;
      partRem <= nextRem;
      quo     <= {quo[operandW-2:0], fits};
    end
  end

endmodule

`default_nettype wire

// File: logic/operandPrep.sv
`timescale 1ns/100ps
`default_nettype none

module operandPrep import rootDivPkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  pop,
  input  rootOpE                headOp,
  input  logic [operandW-1:0]   headA,
  input  logic [operandW-1:0]   headB,
  input  logic [tagW-1:0]       headTag,
  input  logic [regW-1:0]       headReg,
  output logic [2*operandW-1:0] prepA,
  output logic [operandW-1:0]   prepB,
  output logic [stepW-1:0]      prepSteps,
  output logic                  prepIsRoot,
  output logic [tagW-1:0]       prepTag,
  output logic [regW-1:0]       prepReg
);
  localparam int byteW = operandW / 2;

  logic [2*operandW-1:0] alignA;
  logic [operandW-1:0]   maskB;
  logic [stepW-1:0]      steps;
  logic                  isRoot;

  // the core shifts its source out from the top, one bit per divide step
  // and two per root step, so the operand must end where the last step reads
  always_comb begin
    maskB = headB;
    case (headOp)
      opDivW:  alignA = {headA, {operandW{1'b0}}};
      opSqrtW: alignA = {{operandW{1'b0}}, headA};
      opDivB:  alignA = {headA[byteW-1:0], {(2*operandW-byteW){1'b0}}};
      default: alignA = {{byteW{1'b0}}, headA[byteW-1:0], {operandW{1'b0}}};
    endcase
    if (headOp == opDivB || headOp == opSqrtB) begin
      maskB = {{byteW{1'b0}}, headB[byteW-1:0]};  // byte modes ignore upper bits
      steps = stepW'(stepsByte);
    end else begin
      steps = stepW'(stepsWord);
    end
    isRoot = (headOp == opSqrtW) || (headOp == opSqrtB);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      prepSteps  <= '0;
      prepIsRoot <= 1'b0;
    end else if (pop) begin
      prepSteps  <= steps;
      prepIsRoot <= isRoot;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      prepA   <= alignA;
      prepB   <= maskB;
      prepTag <= headTag;
      prepReg <= headReg;
    end
  end

endmodule

`default_nettype wire

// File: logic/opQueue.sv
`timescale 1ns/100ps
`default_nettype none

module opQueue import rootDivPkg::*; #(
  parameter int queueDepth = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                inEn,
  input  rootOpE              inOp,
  input  logic [operandW-1:0] inA,
  input  logic [operandW-1:0] inB,
  input  logic [tagW-1:0]     inTag,
  input  logic [regW-1:0]     inReg,
  input  logic                pop,
  output logic                full,
  output logic                queueValid,
  output rootOpE              headOp,
  output logic [operandW-1:0] headA,
  output logic [operandW-1:0] headB,
  output logic [tagW-1:0]     headTag,
  output logic [regW-1:0]     headReg
);
  localparam int ptrW = (queueDepth > 1) ? $clog2(queueDepth) : 1;
  localparam int cntW = $clog2(queueDepth + 1);

  rootOpE              opMem  [queueDepth];
  logic [operandW-1:0] aMem   [queueDepth];
  logic [operandW-1:0] bMem   [queueDepth];
  logic [tagW-1:0]     tagMem [queueDepth];
  logic [regW-1:0]     regMem [queueDepth];

  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;
  logic            push;

  function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
    return (ptr == ptrW'(queueDepth - 1)) ? '0 : ptr + 1'b1;  // wraps for any depth
  endfunction

  assign push       = inEn && !full;
  assign full       = (count == cntW'(queueDepth));
  assign queueValid = (count != '0);

  // head entry read straight from the buffer
  assign headOp  = opMem[rdPtr];
  assign headA   = aMem[rdPtr];
  assign headB   = bMem[rdPtr];
  assign headTag = tagMem[rdPtr];
  assign headReg = regMem[rdPtr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) wrPtr <= nextPtr(wrPtr);
      if (pop) rdPtr <= nextPtr(rdPtr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      opMem[wrPtr]  <= inOp;
      aMem[wrPtr]   <= inA;
      bMem[wrPtr]   <= inB;
      tagMem[wrPtr] <= inTag;
      regMem[wrPtr] <= inReg;
    end
  end

endmodule

`default_nettype wire

// File: logic/rootDivPkg.sv
`default_nettype none

package rootDivPkg;

  // operand and result widths
  localparam int operandW = 16;
  localparam int resultW  = 32;   // {remainder, quotient or root}

  // bookkeeping carried with each operation
  localparam int tagW = 6;        // matches results to issued ops
  localparam int regW = 5;        // destination register number

  // iteration counts per mode
  localparam int stepsWord = 16;
  localparam int stepsByte = 8;
  localparam int stepW     = 5;   // holds stepsWord

  // word modes work on 16 bits, byte modes on the low 8 bits
  typedef enum logic [1:0] {
    opDivW  = 2'd0,
    opSqrtW = 2'd1,
    opDivB  = 2'd2,
    opSqrtB = 2'd3
  } rootOpE;

endpackage

`default_nettype wire
